/* src/mem_arb_pkg.sv */
`default_nettype none

package mem_arb_pkg;

    // Line format of both caches and the burst memory
    localparam int ADDR_W         = 32;
    localparam int BEAT_W         = 64;
    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;

    // One outstanding read per cache side
    localparam int TRACK_ENTRIES  = 2;

    // Issuer of a memory read
    typedef enum logic {
        OWN_INSTR = 1'b0,
        OWN_DATA  = 1'b1
    } owner_t;

    // Memory port ownership
    typedef enum logic [1:0] {
        ST_IDLE        = 2'd0,
        ST_WRITE_BURST = 2'd1,
        ST_WAIT_READY  = 2'd2
    } arb_state_t;

endpackage : mem_arb_pkg

`default_nettype wire

/* src/arb_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module arb_fsm (
    input  logic clk,
    input  logic rst,
    input  logic imem_read,
    input  logic dmem_read,
    input  logic dmem_write,
    input  logic bmem_ready,
    input  logic wr_last,
    input  logic instr_pending,
    input  logic data_pending,
    output logic grant_instr,
    output logic grant_data_read,
    output logic grant_data_write,
    output logic wr_active,
    output logic wr_done
);
    import mem_arb_pkg::*;

    arb_state_t state;
    arb_state_t state_next;
    logic       idle_ok;
    logic       data_ok;
    logic       wr_accept;

    // Grants are only decided from idle with the memory ready
    assign idle_ok = (state == ST_IDLE) && bmem_ready;

    assign grant_instr = idle_ok && imem_read && !instr_pending;

    // wr_done blocks data, the cache still holds its finished write this cycle
    assign data_ok = idle_ok && !grant_instr && !data_pending && !wr_done;

    assign grant_data_read = data_ok && dmem_read;

    // No write burst while an instruction line is still returning,
    // so a write resp never meets a read resp
    assign grant_data_write = data_ok && dmem_write && !dmem_read && !instr_pending;

    assign wr_active = (state == ST_WRITE_BURST) || (state == ST_WAIT_READY);
    assign wr_accept = wr_active && bmem_ready;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (grant_data_write) begin
                    state_next = ST_WRITE_BURST;
                end
            end
            ST_WRITE_BURST: begin
                if (!bmem_ready) begin
                    state_next = ST_WAIT_READY;
                end else if (wr_last) begin
                    state_next = ST_IDLE;
                end
            end
            ST_WAIT_READY: begin
                // Current beat is held until memory takes it
                if (bmem_ready) begin
                    state_next = wr_last ? ST_IDLE : ST_WRITE_BURST;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            wr_done <= 1'b0;
        end else begin
            state   <= state_next;
            wr_done <= wr_accept && wr_last;
        end
    end

endmodule : arb_fsm

`default_nettype wire

/* src/beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_step,
    input  logic       rd_step,
    output logic [1:0] wr_index,
    output logic [1:0] rd_index,
    output logic       wr_last,
    output logic       rd_last
);

    // Both counters wrap after the fourth beat
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_index <= 2'd0;
            rd_index <= 2'd0;
        end else begin
            if (wr_step) begin
                wr_index <= wr_index + 2'd1;
            end
            if (rd_step) begin
                rd_index <= rd_index + 2'd1;
            end
        end
    end

    assign wr_last = (wr_index == 2'd3);
    assign rd_last = (rd_index == 2'd3);

endmodule : beat_counter

`default_nettype wire

/* src/line_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_serializer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  logic [mem_arb_pkg::LINE_W-1:0]  line,
    input  logic [1:0]                      index,
    output logic [mem_arb_pkg::BEAT_W-1:0]  beat
);
    import mem_arb_pkg::*;

    logic [LINE_W-1:0] line_q;

    // Line is taken in the grant cycle, beats follow from here
    always_ff @(posedge clk) begin
        if (rst) begin
            line_q <= '0;
        end else if (load) begin
            line_q <= line;
        end
    end

    // Beat 0 sits in the low bits
    assign beat = line_q[index*BEAT_W +: BEAT_W];

endmodule : line_serializer

`default_nettype wire

/* src/line_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module line_assembler (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rvalid,
    input  logic [1:0]                      index,
    input  logic [mem_arb_pkg::BEAT_W-1:0]  beat,
    output logic [mem_arb_pkg::LINE_W-1:0]  line
);
    import mem_arb_pkg::*;

    // Last beat is never stored, it goes straight into the line
    logic [BEAT_W-1:0] beat_buf [BEATS_PER_LINE-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BEATS_PER_LINE - 1; i++) begin
                beat_buf[i] <= '0;
            end
        end else if (rvalid && (index != 2'd3)) begin
            beat_buf[index] <= beat;
        end
    end

    assign line = {beat, beat_buf[2], beat_buf[1], beat_buf[0]};

endmodule : line_assembler

`default_nettype wire

/* src/read_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module read_tracker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            issue,
    input  mem_arb_pkg::owner_t             issue_owner,
    input  logic [mem_arb_pkg::ADDR_W-1:0]  issue_addr,
    input  logic                            ret_last,
    input  logic [mem_arb_pkg::ADDR_W-1:0]  ret_addr,
    output mem_arb_pkg::owner_t             ret_owner,
    output logic                            ret_hit,
    output logic                            instr_pending,
    output logic                            data_pending
);
    import mem_arb_pkg::*;

    logic              slot_valid [TRACK_ENTRIES];
    owner_t            slot_owner [TRACK_ENTRIES];
    logic [ADDR_W-1:0] slot_addr  [TRACK_ENTRIES];
    logic [1:0]        hit_vec;
    logic              free_slot;
    logic              hit_slot;
    // Slot filled first, so equal addresses still return in order
    logic              old_slot;

    assign free_slot = slot_valid[0];
    assign hit_vec[0] = slot_valid[0] && (slot_addr[0] == ret_addr);
    assign hit_vec[1] = slot_valid[1] && (slot_addr[1] == ret_addr);
    assign hit_slot  = (&hit_vec) ? old_slot : hit_vec[1];

    assign ret_hit   = ret_last && (|hit_vec);
    assign ret_owner = slot_owner[hit_slot];

    assign instr_pending = (slot_valid[0] && slot_owner[0] == OWN_INSTR) ||
                           (slot_valid[1] && slot_owner[1] == OWN_INSTR);
    assign data_pending  = (slot_valid[0] && slot_owner[0] == OWN_DATA) ||
                           (slot_valid[1] && slot_owner[1] == OWN_DATA);

    // Owner and address are payload, only valid and age are reset
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid[0] <= 1'b0;
            slot_valid[1] <= 1'b0;
            old_slot      <= 1'b0;
        end else begin
            if (issue) begin
                slot_valid[free_slot] <= 1'b1;
            end
            if (ret_hit) begin
                slot_valid[hit_slot] <= 1'b0;
                old_slot <= ~hit_slot;
            end else if (issue && !slot_valid[~free_slot]) begin
                old_slot <= free_slot;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            slot_owner[free_slot] <= issue_owner;
            slot_addr[free_slot]  <= issue_addr;
        end
    end

endmodule : read_tracker

`default_nettype wire

/* src/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                            clk,
    input  logic                            rst,

    // Instruction cache line port
    input  logic [mem_arb_pkg::ADDR_W-1:0]  imem_addr,
    input  logic                            imem_read,
    output logic [mem_arb_pkg::LINE_W-1:0]  imem_rdata,
    output logic                            imem_resp,

    // Data cache line port
    input  logic [mem_arb_pkg::ADDR_W-1:0]  dmem_addr,
    input  logic                            dmem_read,
    input  logic                            dmem_write,
    input  logic [mem_arb_pkg::LINE_W-1:0]  dmem_wdata,
    output logic [mem_arb_pkg::LINE_W-1:0]  dmem_rdata,
    output logic                            dmem_resp,

    // Burst memory
    output logic [mem_arb_pkg::ADDR_W-1:0]  bmem_addr,
    output logic                            bmem_read,
    output logic                            bmem_write,
    output logic [mem_arb_pkg::BEAT_W-1:0]  bmem_wdata,
    input  logic                            bmem_ready,
    input  logic [mem_arb_pkg::BEAT_W-1:0]  bmem_rdata,
    input  logic [mem_arb_pkg::ADDR_W-1:0]  bmem_raddr,
    input  logic                            bmem_rvalid
);
    import mem_arb_pkg::*;

    logic              grant_instr;
    logic              grant_data_read;
    logic              grant_data_write;
    logic              wr_active;
    logic              wr_done;
    logic              wr_step;
    logic [1:0]        wr_index;
    logic [1:0]        rd_index;
    logic              wr_last;
    logic              rd_last;
    logic              instr_pending;
    logic              data_pending;
    owner_t            issue_owner;
    owner_t            ret_owner;
    logic              ret_hit;
    logic [LINE_W-1:0] ret_line;

    arb_fsm u_fsm (
        .clk, .rst, .imem_read, .dmem_read, .dmem_write, .bmem_ready,
        .wr_last, .instr_pending, .data_pending,
        .grant_instr, .grant_data_read, .grant_data_write, .wr_active, .wr_done
    );

    beat_counter u_cnt (
        .clk, .rst, .wr_step, .rd_step(bmem_rvalid),
        .wr_index, .rd_index, .wr_last, .rd_last
    );

    line_serializer u_ser (
        .clk, .rst, .load(grant_data_write), .line(dmem_wdata),
        .index(wr_index), .beat(bmem_wdata)
    );

    line_assembler u_asm (
        .clk, .rst, .rvalid(bmem_rvalid), .index(rd_index),
        .beat(bmem_rdata), .line(ret_line)
    );

    read_tracker u_trk (
        .clk, .rst, .issue(bmem_read), .issue_owner, .issue_addr(bmem_addr),
        .ret_last(bmem_rvalid && rd_last), .ret_addr(bmem_raddr),
        .ret_owner, .ret_hit, .instr_pending, .data_pending
    );

    // The data cache holds its write address for the whole burst
    assign bmem_addr   = grant_instr ? imem_addr : dmem_addr;
    assign bmem_read   = grant_instr || grant_data_read;
    assign wr_step     = wr_active && bmem_ready;
    assign bmem_write  = wr_step;
    assign issue_owner = grant_instr ? OWN_INSTR : OWN_DATA;

    // Both sides see the assembled line, resp tells who owns it
    assign imem_rdata = ret_line;
    assign dmem_rdata = ret_line;
    assign imem_resp  = ret_hit && (ret_owner == OWN_INSTR);
    assign dmem_resp  = wr_done || (ret_hit && (ret_owner == OWN_DATA));

endmodule : mem_arbiter

`default_nettype wire

/* bench/mem_arbiter_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_assert (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            bmem_read,
    input  logic                            bmem_write,
    input  logic                            wr_active,
    input  logic [1:0]                      wr_index,
    input  logic [mem_arb_pkg::ADDR_W-1:0]  bmem_addr,
    input  logic                            imem_resp,
    input  logic                            dmem_resp
);
    import mem_arb_pkg::*;

    int fail_count = 0;

    // No read while a write burst still has beats to send
    a_no_rw: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read && (bmem_write || wr_index != 2'd0)))
        else begin
            fail_count++;
            $error("bmem_read issued inside a write burst");
        end

    // Line address holds from the first beat to the last
    a_wr_addr: assert property (@(posedge clk) disable iff (rst)
        wr_active && $past(wr_active) |-> $stable(bmem_addr))
        else begin
            fail_count++;
            $error("bmem_addr changed inside a write burst");
        end

    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        !(imem_resp && dmem_resp))
        else begin
            fail_count++;
            $error("imem_resp and dmem_resp high in the same cycle");
        end

endmodule : mem_arbiter_assert

bind mem_arbiter mem_arbiter_assert u_assert (
    .clk, .rst, .bmem_read, .bmem_write, .wr_active, .wr_index, .bmem_addr,
    .imem_resp, .dmem_resp
);

`default_nettype wire

/* bench/arb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module arb_checker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mem_arb_pkg::ADDR_W-1:0]  imem_addr,
    input  logic                            imem_read,
    input  logic [mem_arb_pkg::LINE_W-1:0]  imem_rdata,
    input  logic                            imem_resp,
    input  logic [mem_arb_pkg::ADDR_W-1:0]  dmem_addr,
    input  logic                            dmem_read,
    input  logic                            dmem_write,
    input  logic [mem_arb_pkg::LINE_W-1:0]  dmem_wdata,
    input  logic [mem_arb_pkg::LINE_W-1:0]  dmem_rdata,
    input  logic                            dmem_resp
);
    import mem_arb_pkg::*;

    // Memory as the caches have written it
    logic [LINE_W-1:0] shadow [bit [ADDR_W-1:0]];
    int errors = 0;
    int tests = 0;
    int test_errors = 0;
    int n_resp = 0;

    // Never written lines hold a pattern made from the whole address
    function automatic logic [LINE_W-1:0] expected_line(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
            line[i*BEAT_W +: BEAT_W] = {addr ^ 32'h5A5A_0000, addr + 32'(i) * 32'h0101_0101};
        end
        return line;
    endfunction

    task automatic note_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic report_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, test_errors);
        end
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (imem_resp) begin
                n_resp++;
                if (!imem_read) begin
                    note_error("instruction response with no read pending");
                end else if (imem_rdata !== expected_line(imem_addr)) begin
                    $display("mismatch at %0t: imem line %h got %h expected %h",
                             $time, imem_addr, imem_rdata, expected_line(imem_addr));
                    errors++;
                    test_errors++;
                end
            end
            if (dmem_resp) begin
                n_resp++;
                if (dmem_write) begin
                    shadow[dmem_addr] = dmem_wdata;
                end else if (!dmem_read) begin
                    note_error("data response with no request pending");
                end else if (dmem_rdata !== expected_line(dmem_addr)) begin
                    $display("mismatch at %0t: dmem line %h got %h expected %h",
                             $time, dmem_addr, dmem_rdata, expected_line(dmem_addr));
                    errors++;
                    test_errors++;
                end
            end
        end
    end

endmodule : arb_checker

`default_nettype wire

/* bench/tb_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_arbiter;
    import mem_arb_pkg::*;

    localparam int TIMEOUT = 2000;

    logic              clk = 1'b0;
    logic              rst;
    logic [ADDR_W-1:0] imem_addr;
    logic              imem_read;
    logic [LINE_W-1:0] imem_rdata;
    logic              imem_resp;
    logic [ADDR_W-1:0] dmem_addr;
    logic              dmem_read;
    logic              dmem_write;
    logic [LINE_W-1:0] dmem_wdata;
    logic [LINE_W-1:0] dmem_rdata;
    logic              dmem_resp;
    logic [ADDR_W-1:0] bmem_addr;
    logic              bmem_read;
    logic              bmem_write;
    logic [BEAT_W-1:0] bmem_wdata;
    logic              bmem_ready;
    logic [BEAT_W-1:0] bmem_rdata;
    logic [ADDR_W-1:0] bmem_raddr;
    logic              bmem_rvalid;

    int seed = 19;
    bit chaos;
    int wr_cnt;
    int ret_beat;
    int ret_wait;
    int n_req;
    int total_errors;
    int n;
    logic [LINE_W-1:0] wl;

    // Burst memory contents and its queue of reads in flight
    logic [LINE_W-1:0] mem [bit [ADDR_W-1:0]];
    logic [ADDR_W-1:0] rd_q [$];
    logic [LINE_W-1:0] rd_line_q [$];
    logic [ADDR_W-1:0] issue_log [$];
    logic [LINE_W-1:0] wr_buf;

    mem_arbiter UUT (.*);
    arb_checker chk (.*);

    always #50 clk = ~clk;

    function automatic logic [LINE_W-1:0] fill_line(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
            line[i*BEAT_W +: BEAT_W] = {addr ^ 32'h5A5A_0000, addr + 32'(i) * 32'h0101_0101};
        end
        return line;
    endfunction

    function automatic logic [LINE_W-1:0] rand_line();
        logic [LINE_W-1:0] line;
        for (int i = 0; i < 8; i++) begin
            line[i*32 +: 32] = $random(seed);
        end
        return line;
    endfunction

    function automatic logic [ADDR_W-1:0] pick_addr();
        return 32'h0000_1000 + ({$random(seed)} % 8) * 32;
    endfunction

    function automatic int ret_delay();
        return chaos ? 1 + {$random(seed)} % 6 : 2;
    endfunction

    // Memory side takes requests and write beats at the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (bmem_read) begin
                if (wr_cnt != 0) begin
                    chk.note_error("read issued in the middle of a write burst");
                end
                if (rd_q.size() == 0) begin
                    ret_wait = ret_delay();
                end
                rd_q.push_back(bmem_addr);
                rd_line_q.push_back(mem.exists(bmem_addr) ? mem[bmem_addr] : fill_line(bmem_addr));
                issue_log.push_back(bmem_addr);
            end
            if (bmem_write) begin
                wr_buf[wr_cnt*BEAT_W +: BEAT_W] = bmem_wdata;
                if (wr_cnt == 3) begin
                    mem[bmem_addr] = wr_buf;
                    wr_cnt = 0;
                end else begin
                    wr_cnt++;
                end
            end
        end
    end

    // Ready drops and returned beats change on the falling edge
    always @(negedge clk) begin
        bmem_rvalid = 1'b0;
        bmem_ready = !chaos || ({$random(seed)} % 4 != 0);
        if (!rst && rd_q.size() > 0) begin
            if (ret_wait > 0) begin
                ret_wait--;
            end else begin
                bmem_rvalid = 1'b1;
                bmem_raddr = rd_q[0];
                bmem_rdata = rd_line_q[0][ret_beat*BEAT_W +: BEAT_W];
                if (ret_beat == 3) begin
                    void'(rd_q.pop_front());
                    void'(rd_line_q.pop_front());
                    ret_beat = 0;
                    ret_wait = ret_delay();
                end else begin
                    ret_beat++;
                    ret_wait = chaos ? {$random(seed)} % 3 : 0;
                end
            end
        end
    end

    task automatic read_line(input bit instr, input logic [ADDR_W-1:0] addr);
        int cnt;
        bit got;
        @(negedge clk);
        if (instr) begin
            imem_addr = addr;
            imem_read = 1'b1;
        end else begin
            dmem_addr = addr;
            dmem_read = 1'b1;
        end
        cnt = 0;
        do begin
            @(posedge clk);
            got = instr ? imem_resp : dmem_resp;
            cnt++;
        end while (!got && cnt < TIMEOUT);
        if (!got) begin
            chk.note_error(instr ? "timeout waiting for instruction read response"
                                 : "timeout waiting for data read response");
        end
        n_req++;
        @(negedge clk);
        if (instr) begin
            imem_read = 1'b0;
        end else begin
            dmem_read = 1'b0;
        end
    endtask

    task automatic write_line(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
        int cnt;
        bit got;
        @(negedge clk);
        dmem_addr = addr;
        dmem_wdata = line;
        dmem_write = 1'b1;
        cnt = 0;
        do begin
            @(posedge clk);
            got = dmem_resp;
            cnt++;
        end while (!got && cnt < TIMEOUT);
        if (!got) begin
            chk.note_error("timeout waiting for data write response");
        end
        n_req++;
        @(negedge clk);
        dmem_write = 1'b0;
    endtask

    initial begin
        imem_addr = '0;
        imem_read = 1'b0;
        dmem_addr = '0;
        dmem_read = 1'b0;
        dmem_write = 1'b0;
        dmem_wdata = '0;
        bmem_ready = 1'b1;
        bmem_rdata = '0;
        bmem_raddr = '0;
        bmem_rvalid = 1'b0;
        chaos = 1'b0;
        wr_cnt = 0;
        ret_beat = 0;
        ret_wait = 0;
        n_req = 0;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_line(1'b1, 32'h0000_0400);
        chk.report_test("instruction read");

        wl = rand_line();
        write_line(32'h0000_1000, wl);
        read_line(1'b0, 32'h0000_1000);
        write_line(32'h0000_1020, rand_line());
        read_line(1'b0, 32'h0000_1000);
        read_line(1'b0, 32'h0000_1020);
        chk.report_test("data write then read");

        issue_log.delete();
        fork
            read_line(1'b1, 32'h0000_2000);
            read_line(1'b0, 32'h0000_2040);
        join
        if (issue_log.size() < 2 || issue_log[0] !== 32'h0000_2000) begin
            chk.note_error("instruction read was not issued first");
        end
        chk.report_test("same cycle reads");

        wl = rand_line();
        fork
            write_line(32'h0000_3000, wl);
            begin
                n = 0;
                while (wr_cnt == 0 && n < TIMEOUT) begin
                    @(negedge clk);
                    n++;
                end
                if (wr_cnt == 0) begin
                    chk.note_error("timeout waiting for the first write beat");
                end
                read_line(1'b1, 32'h0000_3020);
            end
        join
        if (!mem.exists(32'h0000_3000) || mem[32'h0000_3000] !== wl) begin
            chk.note_error("write beats did not arrive in order 0 to 3");
        end
        chk.report_test("read during write burst");

        chaos = 1'b1;
        fork
            for (int k = 0; k < 20; k++) begin
                read_line(1'b1, pick_addr());
            end
            for (int k = 0; k < 20; k++) begin
                if ({$random(seed)} % 2) begin
                    write_line(pick_addr(), rand_line());
                end else begin
                    read_line(1'b0, pick_addr());
                end
            end
        join
        chaos = 1'b0;
        repeat (4) @(negedge clk);
        if (chk.n_resp != n_req) begin
            chk.note_error("response count does not match request count");
        end
        chk.report_test("random mixed traffic");

        total_errors = chk.errors + UUT.u_assert.fail_count;
        $display("tests %0d, errors %0d", chk.tests, total_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_mem_arbiter

`default_nettype wire

/* filelist.f */
src/mem_arb_pkg.sv
src/arb_fsm.sv
src/beat_counter.sv
src/line_serializer.sv
src/line_assembler.sv
src/read_tracker.sv
src/mem_arbiter.sv
bench/mem_arbiter_assert.sv
bench/arb_checker.sv
bench/tb_mem_arbiter.sv
